//--- all.f
+incdir+include
design/l1_cache_pkg.sv
design/cache_array.sv
design/cache_ctrl.sv
design/mem_port.sv
design/l1_cache.sv
sim/tb_mem_model.sv
sim/tb_l1_cache.sv

//--- design/cache_array.sv
// cache frame storage: one frame per set, combinational read with tag compare, hit/fill writes
`timescale 1ns/1ps
`include "l1_cache_defines.svh"

module cache_array (
    input  logic                      CLK,
    input  logic                      nRST,
    input  l1_cache_pkg::set_idx_t    idx,
    input  l1_cache_pkg::tag_t        tag,
    output l1_cache_pkg::cache_frame_t frame,
    output logic                      hit,
    input  logic                      hit_we,
    input  l1_cache_pkg::block_off_t  hit_off,
    input  l1_cache_pkg::word_t       hit_data,
    input  logic                      fill_we,
    input  l1_cache_pkg::block_off_t  fill_off,
    input  l1_cache_pkg::word_t       fill_data,
    input  logic                      fill_tag_we,
    input  logic                      inval
);

    logic [`L1_N_SETS-1:0] valid_q;
    logic [`L1_N_SETS-1:0] dirty_q;
    l1_cache_pkg::tag_t    tag_q  [`L1_N_SETS];
    l1_cache_pkg::block_t  data_q [`L1_N_SETS];

    // status bits per set
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (inval) begin
                valid_q[idx] <= 1'b0;
                dirty_q[idx] <= 1'b0;
            end else if (fill_tag_we) begin
                valid_q[idx] <= 1'b1;  // fresh block from memory is clean
                dirty_q[idx] <= 1'b0;
            end else if (hit_we) begin
                dirty_q[idx] <= 1'b1;
            end
        end
    end

    // tag and data payload
    always_ff @(posedge CLK) begin
        if (fill_tag_we) begin
            tag_q[idx] <= tag;
        end
        if (fill_we) begin
            data_q[idx][fill_off] <= fill_data;
        end
        if (hit_we) begin
            data_q[idx][hit_off] <= hit_data;
        end
    end

    // indexed frame, read without a clock
    always_comb begin
        frame.valid = valid_q[idx];
        frame.dirty = dirty_q[idx];
        frame.tag   = tag_q[idx];
        frame.data  = data_q[idx];
    end

    assign hit = valid_q[idx] && (tag_q[idx] == tag);

endmodule

//--- design/cache_ctrl.sv
// cache controller FSM: serves hits, starts fills and write-backs, sweeps all sets on flush
`timescale 1ns/1ps
`include "l1_cache_defines.svh"

module cache_ctrl (
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic                       flush,
    output logic                       flush_done,
    input  logic                       ren,
    input  logic                       wen,
    input  l1_cache_pkg::word_t        addr,
    input  l1_cache_pkg::word_t        wdata,
    output l1_cache_pkg::word_t        rdata,
    output logic                       busy,
    input  l1_cache_pkg::cache_frame_t frame,
    input  logic                       hit,
    output l1_cache_pkg::set_idx_t     idx,
    output l1_cache_pkg::tag_t         tag,
    output logic                       hit_we,
    output l1_cache_pkg::block_off_t   hit_off,
    output l1_cache_pkg::word_t        hit_data,
    output logic                       fill_tag_we,
    output logic                       inval,
    output l1_cache_pkg::mem_cmd_e     cmd,
    output l1_cache_pkg::word_t        base_addr,
    output l1_cache_pkg::block_t       wb_block,
    input  logic                       block_done
);

    l1_cache_pkg::cache_state_e state_q, state_n;
    l1_cache_pkg::set_idx_t     flush_set_q, flush_set_n;
    l1_cache_pkg::tag_t         req_tag;
    l1_cache_pkg::set_idx_t     req_idx;
    l1_cache_pkg::block_off_t   req_off;
    logic                       flush_q;
    logic                       flush_pend;
    logic                       req;

    // address fields: tag | set | word offset | byte
    assign req_tag = addr[`L1_WORD_W-1 -: `L1_TAG_BITS];
    assign req_idx = addr[2+`L1_BLOCK_BITS +: `L1_SET_BITS];
    assign req_off = addr[2 +: `L1_BLOCK_BITS];

    assign req        = ren | wen;
    assign flush_pend = flush | flush_q;

    assign tag      = req_tag;
    assign hit_off  = req_off;
    assign hit_data = wdata;
    assign rdata    = frame.data[req_off];
    assign wb_block = frame.data;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state_q     <= l1_cache_pkg::CACHE_IDLE;
            flush_set_q <= '0;
            flush_q     <= 1'b0;
        end else begin
            state_q     <= state_n;
            flush_set_q <= flush_set_n;
            if (state_q == l1_cache_pkg::CACHE_FLUSH) begin
                flush_q <= 1'b0;  // consumed by the sweep
            end else if (flush) begin
                flush_q <= 1'b1;
            end
        end
    end

    always_comb begin
        state_n     = state_q;
        flush_set_n = flush_set_q;
        busy        = 1'b1;
        idx         = req_idx;
        hit_we      = 1'b0;
        fill_tag_we = 1'b0;
        inval       = 1'b0;
        flush_done  = 1'b0;
        cmd         = l1_cache_pkg::MEM_NONE;
        base_addr   = {req_tag, req_idx, {`L1_BLOCK_BITS{1'b0}}, 2'b00};

        case (state_q)
            l1_cache_pkg::CACHE_IDLE: begin
                if (flush_pend) begin
                    state_n = l1_cache_pkg::CACHE_FLUSH;  // flush wins over a waiting request
                end else if (req && hit) begin
                    busy   = 1'b0;
                    hit_we = wen;
                end else if (req) begin
                    if (frame.valid && frame.dirty) begin
                        state_n = l1_cache_pkg::CACHE_WB;
                    end else begin
                        state_n = l1_cache_pkg::CACHE_FETCH;
                    end
                end
            end

            l1_cache_pkg::CACHE_FETCH: begin
                cmd = l1_cache_pkg::MEM_FETCH;
                if (block_done) begin
                    fill_tag_we = 1'b1;  // last word lands with the tag
                    state_n     = l1_cache_pkg::CACHE_IDLE;
                end
            end

            l1_cache_pkg::CACHE_WB: begin
                cmd       = l1_cache_pkg::MEM_WRITEBACK;
                base_addr = {frame.tag, req_idx, {`L1_BLOCK_BITS{1'b0}}, 2'b00};
                // victim goes invalid, the idle pass then sees a clean miss
                if (block_done) begin
                    inval   = 1'b1;
                    state_n = l1_cache_pkg::CACHE_IDLE;
                end
            end

            l1_cache_pkg::CACHE_FLUSH: begin
                idx = flush_set_q;
                if (frame.valid && frame.dirty) begin
                    cmd       = l1_cache_pkg::MEM_WRITEBACK;
                    base_addr = {frame.tag, flush_set_q, {`L1_BLOCK_BITS{1'b0}}, 2'b00};
                    inval     = block_done;  // set is revisited clean next cycle
                end else begin
                    inval = 1'b1;
                    if (flush_set_q == l1_cache_pkg::set_idx_t'(`L1_N_SETS - 1)) begin
                        flush_done  = 1'b1;
                        flush_set_n = '0;
                        state_n     = l1_cache_pkg::CACHE_IDLE;
                    end else begin
                        flush_set_n = flush_set_q + 1'b1;
                    end
                end
            end

            default: begin
                state_n = l1_cache_pkg::CACHE_IDLE;
            end
        endcase
    end

endmodule

//--- design/l1_cache.sv
// l1 write-back data cache top: frame array, controller and memory port between the two buses
`timescale 1ns/1ps

module l1_cache (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                flush,
    output logic                flush_done,
    input  logic                ren,
    input  logic                wen,
    input  l1_cache_pkg::word_t addr,
    input  l1_cache_pkg::word_t wdata,
    output l1_cache_pkg::word_t rdata,
    output logic                busy,
    output logic                mem_ren,
    output logic                mem_wen,
    output l1_cache_pkg::word_t mem_addr,
    output l1_cache_pkg::word_t mem_wdata,
    input  l1_cache_pkg::word_t mem_rdata,
    input  logic                mem_busy
);

    // array side
    l1_cache_pkg::cache_frame_t frame;
    l1_cache_pkg::set_idx_t     idx;
    l1_cache_pkg::tag_t         tag;
    l1_cache_pkg::block_off_t   hit_off;
    l1_cache_pkg::block_off_t   fill_off;
    l1_cache_pkg::word_t        hit_data;
    l1_cache_pkg::word_t        fill_data;
    logic                       hit;
    logic                       hit_we;
    logic                       fill_we;
    logic                       fill_tag_we;
    logic                       inval;

    // controller to memory port
    l1_cache_pkg::mem_cmd_e     cmd;
    l1_cache_pkg::word_t        base_addr;
    l1_cache_pkg::block_t       wb_block;
    logic                       block_done;

    cache_array u_array (
        .CLK(CLK), .nRST(nRST),
        .idx(idx), .tag(tag), .frame(frame), .hit(hit),
        .hit_we(hit_we), .hit_off(hit_off), .hit_data(hit_data),
        .fill_we(fill_we), .fill_off(fill_off), .fill_data(fill_data),
        .fill_tag_we(fill_tag_we), .inval(inval)
    );

    cache_ctrl u_ctrl (
        .CLK(CLK), .nRST(nRST),
        .flush(flush), .flush_done(flush_done),
        .ren(ren), .wen(wen), .addr(addr), .wdata(wdata), .rdata(rdata), .busy(busy),
        .frame(frame), .hit(hit), .idx(idx), .tag(tag),
        .hit_we(hit_we), .hit_off(hit_off), .hit_data(hit_data),
        .fill_tag_we(fill_tag_we), .inval(inval),
        .cmd(cmd), .base_addr(base_addr), .wb_block(wb_block), .block_done(block_done)
    );

    mem_port u_port (
        .CLK(CLK), .nRST(nRST),
        .cmd(cmd), .base_addr(base_addr), .wb_block(wb_block), .block_done(block_done),
        .fill_we(fill_we), .fill_off(fill_off), .fill_data(fill_data),
        .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata), .mem_busy(mem_busy)
    );

endmodule

//--- design/l1_cache_pkg.sv
// l1 data cache types: address fields, frame layout, controller states and memory commands
`include "l1_cache_defines.svh"

package l1_cache_pkg;

    typedef logic [`L1_WORD_W-1:0]     word_t;
    typedef logic [`L1_TAG_BITS-1:0]   tag_t;
    typedef logic [`L1_SET_BITS-1:0]   set_idx_t;
    typedef logic [`L1_BLOCK_BITS-1:0] block_off_t;

    // word 0 sits in the low bits
    typedef logic [`L1_BLOCK_WORDS-1:0][`L1_WORD_W-1:0] block_t;

    typedef struct packed {
        logic   valid;
        logic   dirty;
        tag_t   tag;
        block_t data;
    } cache_frame_t;

    typedef enum logic [1:0] {
        CACHE_IDLE,
        CACHE_FETCH,
        CACHE_WB,
        CACHE_FLUSH
    } cache_state_e;

    // block transfer requested from the memory port
    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_FETCH,
        MEM_WRITEBACK
    } mem_cmd_e;

endpackage

//--- design/mem_port.sv
// memory port sequencer: moves one block word by word over the busy-handshake memory bus
`timescale 1ns/1ps
`include "l1_cache_defines.svh"

module mem_port (
    input  logic                     CLK,
    input  logic                     nRST,
    input  l1_cache_pkg::mem_cmd_e   cmd,
    input  l1_cache_pkg::word_t      base_addr,
    input  l1_cache_pkg::block_t     wb_block,
    output logic                     block_done,
    output logic                     fill_we,
    output l1_cache_pkg::block_off_t fill_off,
    output l1_cache_pkg::word_t      fill_data,
    output logic                     mem_ren,
    output logic                     mem_wen,
    output l1_cache_pkg::word_t      mem_addr,
    output l1_cache_pkg::word_t      mem_wdata,
    input  l1_cache_pkg::word_t      mem_rdata,
    input  logic                     mem_busy
);

    l1_cache_pkg::block_off_t cnt_q;
    logic                     wait_q;  // block finished, cmd not yet dropped
    logic                     active;
    logic                     accept;
    logic                     last;

    assign active = (cmd != l1_cache_pkg::MEM_NONE) && !wait_q;
    assign accept = active && !mem_busy;
    assign last   = (cnt_q == l1_cache_pkg::block_off_t'(`L1_BLOCK_WORDS - 1));

    assign mem_ren   = active && (cmd == l1_cache_pkg::MEM_FETCH);
    assign mem_wen   = active && (cmd == l1_cache_pkg::MEM_WRITEBACK);
    assign mem_addr  = base_addr + {{(`L1_WORD_W - `L1_BLOCK_BITS - 2){1'b0}}, cnt_q, 2'b00};
    assign mem_wdata = wb_block[cnt_q];

    assign block_done = accept && last;

    // fetched words go straight into the frame
    assign fill_we   = accept && (cmd == l1_cache_pkg::MEM_FETCH);
    assign fill_off  = cnt_q;
    assign fill_data = mem_rdata;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            cnt_q  <= '0;
            wait_q <= 1'b0;
        end else begin
            if (accept) begin
                cnt_q <= last ? '0 : cnt_q + 1'b1;  // hold while memory is busy
            end
            if (block_done) begin
                wait_q <= 1'b1;
            end else if (cmd == l1_cache_pkg::MEM_NONE) begin
                wait_q <= 1'b0;
            end
        end
    end

endmodule

//--- include/l1_cache_defines.svh
// l1 data cache sizing: word width, block size, set count and derived address field widths
`ifndef L1_CACHE_DEFINES_SVH
`define L1_CACHE_DEFINES_SVH

// one data or address word
`define L1_WORD_W       32

// words per block
`define L1_BLOCK_WORDS  2

// direct-mapped, so one frame per set
`define L1_N_SETS       16

`define L1_SET_BITS     4
`define L1_BLOCK_BITS   1

// tag takes what is left after set, word offset and the two byte bits
`define L1_TAG_BITS     (`L1_WORD_W - `L1_SET_BITS - `L1_BLOCK_BITS - 2)

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the l1 cache testbench with Verilator, pass is read from the log

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing -f all.f --top-module tb_l1_cache -o tb_l1_cache
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_l1_cache > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "SIMULATION PASSED" "$log"; then
    exit 0
else
    echo "pass message not found in $log"
    exit 1
fi

//--- sim/tb_l1_cache.sv
// testbench for the l1 write-back cache with random cpu traffic against a shadow memory and a final flush
`timescale 1ns/1ps

module tb_l1_cache;

    localparam int          N_OPS     = 400;  // random accesses
    localparam int          POOL_SIZE = 24;   // 4 tags x 3 sets x 2 words
    localparam int          TIMEOUT   = (N_OPS + 16) * 20;
    localparam logic [31:0] SEED      = 32'h2a62;

    logic                CLK, nRST;
    logic                flush, flush_done;
    logic                ren, wen, busy;
    l1_cache_pkg::word_t addr, wdata, rdata;
    logic                mem_ren, mem_wen, mem_busy;
    l1_cache_pkg::word_t mem_addr, mem_wdata, mem_rdata;

    l1_cache_pkg::word_t shadow [1024];
    int                  cycles      = 0;
    int                  ren_words   = 0;
    int                  wen_words   = 0;
    int                  done_pulses = 0;

    l1_cache UUT (
        .CLK(CLK), .nRST(nRST), .flush(flush), .flush_done(flush_done),
        .ren(ren), .wen(wen), .addr(addr), .wdata(wdata), .rdata(rdata), .busy(busy),
        .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata), .mem_busy(mem_busy)
    );

    tb_mem_model mem (
        .CLK(CLK), .nRST(nRST), .mem_ren(mem_ren), .mem_wen(mem_wen),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
        .mem_busy(mem_busy)
    );

    always #50 CLK = ~CLK;

    // preload value of a memory word
    function automatic l1_cache_pkg::word_t fill_pattern(input logic [9:0] i);
        return {6'h2d, i, 6'h12, ~i};
    endfunction

    // tag in bits 7 and up, set in 3..6, word offset in bit 2
    function automatic l1_cache_pkg::word_t pool_addr(input int k);
        return l1_cache_pkg::word_t'((k / 6) * 128 + ((k / 2) % 3) * 8 + (k % 2) * 4);
    endfunction

    // shadow memory where a write updates the word and a read returns it
    function automatic l1_cache_pkg::word_t ref_access(input logic is_wr,
            input l1_cache_pkg::word_t a, input l1_cache_pkg::word_t d);
        if (is_wr) begin
            shadow[a[11:2]] = d;
        end
        return shadow[a[11:2]];
    endfunction

    task automatic compare_word(input string name, input l1_cache_pkg::word_t exp,
            input l1_cache_pkg::word_t got);
        if (got !== exp) begin
            $display("** Error %s expected 0x%08h got 0x%08h", name, exp, got);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // one cpu request held until busy is seen low
    // starts and ends 1 ns after a rising edge
    task automatic cpu_access(input logic is_wr, input l1_cache_pkg::word_t a,
            input l1_cache_pkg::word_t d, output l1_cache_pkg::word_t rd, output int waits);
        ren   = !is_wr;
        wen   = is_wr;
        addr  = a;
        wdata = d;
        waits = 0;
        @(negedge CLK);
        while (busy) begin
            waits++;
            @(negedge CLK);
        end
        rd = rdata;
        @(posedge CLK);  // request completes here
        #1;
        ren = 1'b0;
        wen = 1'b0;
    endtask

    // bus activity counted mid-cycle
    always @(negedge CLK) begin
        if (mem_ren && !mem_busy) begin
            ren_words++;
        end
        if (mem_wen && !mem_busy) begin
            wen_words++;
        end
        if (flush_done) begin
            done_pulses++;
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        l1_cache_pkg::word_t a, d, got, exp;
        int                  k, waits, ren0, wen0, done0;
        logic                is_wr;

        d     = $urandom(SEED);
        CLK   = 1'b0;
        nRST  = 1'b0;
        flush = 1'b0;
        ren   = 1'b0;
        wen   = 1'b0;
        addr  = '0;
        wdata = '0;
        for (int i = 0; i < 1024; i++) begin
            shadow[i] = fill_pattern(10'(i));
        end

        repeat (2) @(posedge CLK);
        @(negedge CLK);
        compare_word("busy", 32'd1, l1_cache_pkg::word_t'(busy));
        compare_word("mem_ren", 32'd0, l1_cache_pkg::word_t'(mem_ren));
        compare_word("mem_wen", 32'd0, l1_cache_pkg::word_t'(mem_wen));
        compare_word("flush_done", 32'd0, l1_cache_pkg::word_t'(flush_done));
        @(posedge CLK);
        #1;
        nRST = 1'b1;
        @(negedge CLK);
        compare_word("busy", 32'd1, l1_cache_pkg::word_t'(busy));
        @(posedge CLK);
        #1;

        // cold read fills the block and a second read hits at once
        a    = pool_addr(2);
        ren0 = ren_words;
        cpu_access(1'b0, a, '0, got, waits);
        compare_word("rdata", ref_access(1'b0, a, '0), got);
        compare_word("fill words", 32'd2, l1_cache_pkg::word_t'(ren_words - ren0));
        cpu_access(1'b0, a, '0, got, waits);
        compare_word("rdata", ref_access(1'b0, a, '0), got);
        compare_word("hit wait cycles", 32'd0, l1_cache_pkg::word_t'(waits));

        // write hit stays in the cache
        wen0 = wen_words;
        d    = 32'hcafe_0123;
        exp  = ref_access(1'b1, a, d);
        cpu_access(1'b1, a, d, got, waits);
        cpu_access(1'b0, a, '0, got, waits);
        compare_word("rdata", exp, got);
        compare_word("write cycles", 32'd0, l1_cache_pkg::word_t'(wen_words - wen0));

        for (int n = 0; n < N_OPS; n++) begin
            k     = int'($urandom % POOL_SIZE);
            is_wr = ($urandom % 2) == 1;
            d     = $urandom;
            a     = pool_addr(k);
            exp   = ref_access(is_wr, a, d);
            cpu_access(is_wr, a, d, got, waits);
            if (!is_wr) begin
                compare_word("rdata", exp, got);
            end
        end
        compare_word("write-back seen", 32'd1, l1_cache_pkg::word_t'(wen_words > wen0));

        // a dirty block at address 0 that the flush has to write back and drop
        a   = pool_addr(0);
        d   = $urandom;
        exp = ref_access(1'b1, a, d);
        cpu_access(1'b1, a, d, got, waits);

        // flush pulse and then a full memory compare against the shadow
        done0 = done_pulses;
        flush = 1'b1;
        @(posedge CLK);
        #1;
        flush = 1'b0;
        while (done_pulses == done0) begin
            @(posedge CLK);
        end
        repeat (2) @(posedge CLK);
        #1;
        compare_word("flush_done pulses", 32'd1, l1_cache_pkg::word_t'(done_pulses - done0));
        for (int i = 0; i < 1024; i++) begin
            compare_word($sformatf("mem.words[%0d]", i), shadow[i], mem.words[i]);
        end

        // everything is invalid now so the read of address 0 goes back to memory
        ren0 = ren_words;
        cpu_access(1'b0, a, '0, got, waits);
        compare_word("rdata", ref_access(1'b0, a, '0), got);
        compare_word("refetch words", 32'd2, l1_cache_pkg::word_t'(ren_words - ren0));

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- sim/tb_mem_model.sv
// behavioral memory for the cache testbench: preloaded word array with random busy wait states
`timescale 1ns/1ps

module tb_mem_model (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                mem_ren,
    input  logic                mem_wen,
    input  l1_cache_pkg::word_t mem_addr,
    input  l1_cache_pkg::word_t mem_wdata,
    output l1_cache_pkg::word_t mem_rdata,
    output logic                mem_busy
);

    localparam int N_WORDS = 1024;

    l1_cache_pkg::word_t words [N_WORDS];
    logic [1:0]          wait_q;  // busy cycles left before the current word is taken
    logic [9:0]          widx;
    logic                accept;

    assign widx      = mem_addr[11:2];
    assign mem_rdata = words[widx];
    assign mem_busy  = (mem_ren || mem_wen) && (wait_q != 2'd0);
    assign accept    = (mem_ren || mem_wen) && (wait_q == 2'd0);

    // every word differs, built from the full word index
    initial begin
        for (int i = 0; i < N_WORDS; i++) begin
            words[i] = {6'h2d, i[9:0], 6'h12, ~i[9:0]};
        end
    end

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wait_q <= 2'd1;
        end else if (mem_ren || mem_wen) begin
            if (wait_q != 2'd0) begin
                wait_q <= wait_q - 2'd1;
            end else begin
                wait_q <= 2'($urandom % 3);  // 0 to 2 busy cycles for the next word
            end
        end
    end

    always @(posedge CLK) begin
        if (accept && mem_wen) begin
            words[widx] <= mem_wdata;
        end
    end

endmodule
